//--- hdl/debug_consts.svh
`ifndef DEBUG_CONSTS_SVH
`define DEBUG_CONSTS_SVH

// serial bit time in clk cycles
// kept small so simulation runs short
`define DBG_CLKS_PER_BIT 8

// transmit FIFO entries, power of two
`define DBG_FIFO_DEPTH 16

// instruction memory words, power of two
`define DBG_IMEM_WORDS 16

// host command bytes, ascii W S P R
`define DBG_CMD_WRITE 8'h57
`define DBG_CMD_STEP  8'h53
`define DBG_CMD_PEEK  8'h50
`define DBG_CMD_RESET 8'h52

// answer bytes, ascii K and ?
`define DBG_ANS_OK  8'h4b
`define DBG_ANS_BAD 8'h3f

`endif

//--- hdl/uart_pkg.sv
package uart_pkg;

	// serial payload, one frame
	typedef logic [7:0] byte_t;

	// receiver phases
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// transmitter phases
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

//--- hdl/debug_pkg.sv
package debug_pkg;

	// pc and instruction width of the fetch stage
	typedef logic [31:0] word_t;

	// command FSM
	// idle    waiting for a command byte
	// collect gathering the four W data bytes
	// step    one-cycle fetch step before a dump
	// dump    pushing pc and instr, eight bytes
	// answer  pushing a single K or ?
	typedef enum logic [2:0] {
		DBG_IDLE,
		DBG_COLLECT,
		DBG_STEP,
		DBG_DUMP,
		DBG_ANSWER
	} dbg_state_t;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ps
`include "debug_consts.svh"

module uart_rx (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            rx,
	output uart_pkg::byte_t rx_byte,
	output logic            rx_valid
);
	localparam int CLKS = `DBG_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS);
	localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS / 2 - 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS - 1);

	uart_pkg::rx_state_t state;
	logic                rx_meta;
	logic                rx_sync;
	logic [CNT_W-1:0]    cnt;
	logic [2:0]          bit_idx;
	uart_pkg::byte_t     shreg;

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// frame FSM
	// start bit checked at mid-bit, then every full bit time
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= uart_pkg::RX_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE: begin
					cnt <= '0;
					// falling edge of start bit
					if (!rx_sync)
						state <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START: begin
					if (cnt == HALF) begin
						cnt     <= '0;
						bit_idx <= '0;
						// glitch, line back high
						state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				uart_pkg::RX_DATA: begin
					if (cnt == LAST) begin
						cnt <= '0;
						if (bit_idx == 3'd7)
							state <= uart_pkg::RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					// middle of stop bit, no framing check
					if (cnt == LAST) begin
						rx_valid <= 1'b1;
						state    <= uart_pkg::RX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && cnt == LAST)
			shreg <= {rx_sync, shreg[7:1]};
	end

	assign rx_byte = shreg;

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps
`include "debug_consts.svh"

module uart_tx (
	input  logic            clk,
	input  logic            rst_n,
	input  uart_pkg::byte_t head_byte,
	input  logic            empty,
	output logic            pop,
	output logic            tx
);
	localparam int CLKS = `DBG_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS - 1);

	uart_pkg::tx_state_t state;
	logic [CNT_W-1:0]    cnt;
	logic [2:0]          bit_idx;
	uart_pkg::byte_t     shreg;

	// fifo head is fall-through, take it as we leave idle
	assign pop = (state == uart_pkg::TX_IDLE) && !empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= uart_pkg::TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				uart_pkg::TX_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (!empty)
						state <= uart_pkg::TX_START;
				end
				uart_pkg::TX_START: begin
					cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
					if (cnt == LAST)
						state <= uart_pkg::TX_DATA;
				end
				uart_pkg::TX_DATA: begin
					cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
					if (cnt == LAST) begin
						if (bit_idx == 3'd7)
							state <= uart_pkg::TX_STOP;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				default: begin
					cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
					if (cnt == LAST)
						state <= uart_pkg::TX_IDLE;
				end
			endcase
		end
	end

	// shift register, lsb goes out first
	always_ff @(posedge clk) begin
		if (pop)
			shreg <= head_byte;
		else if (state == uart_pkg::TX_DATA && cnt == LAST)
			shreg <= {1'b0, shreg[7:1]};
	end

	// line level per phase
	always_comb begin
		case (state)
			uart_pkg::TX_START: tx = 1'b0;
			uart_pkg::TX_DATA:  tx = shreg[0];
			default:            tx = 1'b1;
		endcase
	end

endmodule

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps
`include "debug_consts.svh"

module byte_fifo (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            push,
	input  uart_pkg::byte_t push_byte,
	input  logic            pop,
	output uart_pkg::byte_t head_byte,
	output logic            full,
	output logic            empty
);
	localparam int DEPTH = `DBG_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	uart_pkg::byte_t mem [DEPTH];
	// extra msb tells full from empty
	logic [AW:0]     wr_ptr;
	logic [AW:0]     rd_ptr;
	logic            do_push;
	logic            do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= push_byte;
	end

	// first-word fall-through head
	assign head_byte = mem[rd_ptr[AW-1:0]];
	assign empty     = (wr_ptr == rd_ptr);
	assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "debug_consts.svh"

module fetch_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             step,
	input  logic             clear,
	input  logic             wr_en,
	input  debug_pkg::word_t wr_data,
	output debug_pkg::word_t pc,
	output debug_pkg::word_t instr
);
	localparam int WORDS = `DBG_IMEM_WORDS;
	localparam int IDX_W = $clog2(WORDS);
	// byte address wraps at four times the word count
	localparam debug_pkg::word_t PC_MASK = 32'(WORDS * 4 - 1);

	debug_pkg::word_t pc_q;
	logic [IDX_W-1:0] wr_idx;
	debug_pkg::word_t mem [WORDS];

	//////////////////////////////////////////////////////////////////////
	// pc and write index
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q   <= '0;
			wr_idx <= '0;
		end else if (clear) begin
			// clear wins over step
			pc_q   <= '0;
			wr_idx <= '0;
		end else begin
			if (step)
				pc_q <= (pc_q + 32'd4) & PC_MASK;
			if (wr_en)
				wr_idx <= wr_idx + 1'b1;
		end
	end

	// instruction memory, zero after reset, kept over clear
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < WORDS; i++)
				mem[i] <= '0;
		end else if (wr_en) begin
			mem[wr_idx] <= wr_data;
		end
	end

	assign pc    = pc_q;
	// word index is pc / 4
	assign instr = mem[pc_q[IDX_W+1:2]];

endmodule

//--- hdl/debug_unit.sv
`timescale 1ns/1ps
`include "debug_consts.svh"

module debug_unit (
	input  logic             clk,
	input  logic             rst_n,
	input  uart_pkg::byte_t  rx_byte,
	input  logic             rx_valid,
	input  debug_pkg::word_t pc,
	input  debug_pkg::word_t instr,
	output logic             step,
	output logic             clear,
	output logic             wr_en,
	output debug_pkg::word_t wr_data,
	output logic             push,
	output uart_pkg::byte_t  push_byte,
	input  logic             full
);
	debug_pkg::dbg_state_t state;
	logic [1:0]            col_cnt;
	logic [2:0]            dump_cnt;
	// snapshot taken in first dump cycle
	logic                  snap_ok;
	logic [63:0]           snap;
	uart_pkg::byte_t       ans_byte;
	logic                  wr_en_q;
	logic                  clear_q;

	//////////////////////////////////////////////////////////////////////
	// command FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= debug_pkg::DBG_IDLE;
			col_cnt  <= '0;
			dump_cnt <= '0;
			snap_ok  <= 1'b0;
			wr_en_q  <= 1'b0;
			clear_q  <= 1'b0;
		end else begin
			// single-cycle strobes
			wr_en_q <= 1'b0;
			clear_q <= 1'b0;
			case (state)
				debug_pkg::DBG_IDLE: begin
					if (rx_valid) begin
						case (rx_byte)
							`DBG_CMD_WRITE: begin
								col_cnt <= '0;
								state   <= debug_pkg::DBG_COLLECT;
							end
							`DBG_CMD_STEP: state <= debug_pkg::DBG_STEP;
							`DBG_CMD_PEEK: state <= debug_pkg::DBG_DUMP;
							`DBG_CMD_RESET: begin
								clear_q <= 1'b1;
								state   <= debug_pkg::DBG_ANSWER;
							end
							default: state <= debug_pkg::DBG_ANSWER;
						endcase
					end
				end
				debug_pkg::DBG_COLLECT: begin
					// fourth data byte completes the word
					if (rx_valid) begin
						col_cnt <= col_cnt + 1'b1;
						if (col_cnt == 2'd3) begin
							wr_en_q <= 1'b1;
							state   <= debug_pkg::DBG_ANSWER;
						end
					end
				end
				// step strobe lives in this state
				debug_pkg::DBG_STEP: state <= debug_pkg::DBG_DUMP;
				debug_pkg::DBG_DUMP: begin
					if (!snap_ok) begin
						snap_ok <= 1'b1;
					end else if (!full) begin
						dump_cnt <= dump_cnt + 1'b1;
						if (dump_cnt == 3'd7) begin
							snap_ok <= 1'b0;
							state   <= debug_pkg::DBG_IDLE;
						end
					end
				end
				default: begin
					// single answer byte, wait for room
					if (!full)
						state <= debug_pkg::DBG_IDLE;
				end
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (state == debug_pkg::DBG_IDLE && rx_valid)
			ans_byte <= (rx_byte == `DBG_CMD_WRITE || rx_byte == `DBG_CMD_RESET) ?
				`DBG_ANS_OK : `DBG_ANS_BAD;
		// lsb arrives first
		if (state == debug_pkg::DBG_COLLECT && rx_valid)
			wr_data <= {rx_byte, wr_data[31:8]};
		// pc in low half, instr in high half
		if (state == debug_pkg::DBG_DUMP && !snap_ok)
			snap <= {instr, pc};
	end

	assign step  = (state == debug_pkg::DBG_STEP);
	assign wr_en = wr_en_q;
	assign clear = clear_q;

	// fifo push, byte held while full
	always_comb begin
		push      = 1'b0;
		push_byte = ans_byte;
		if (state == debug_pkg::DBG_ANSWER) begin
			push = !full;
		end else if (state == debug_pkg::DBG_DUMP && snap_ok) begin
			push      = !full;
			push_byte = snap[{dump_cnt, 3'b000} +: 8];
		end
	end

endmodule

//--- hdl/debug_top.sv
`timescale 1ns/1ps

module debug_top (
	input  logic clk,
	input  logic rst_n,
	input  logic rx,
	output logic tx
);
	// receive side
	uart_pkg::byte_t  rx_byte;
	logic             rx_valid;
	// fetch stage control and status
	debug_pkg::word_t pc;
	debug_pkg::word_t instr;
	logic             step;
	logic             clear;
	logic             wr_en;
	debug_pkg::word_t wr_data;
	// answer path into the transmit fifo
	logic             push;
	uart_pkg::byte_t  push_byte;
	logic             full;
	uart_pkg::byte_t  head_byte;
	logic             empty;
	logic             pop;

	uart_rx uart_rx_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx       (rx),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	debug_unit debug_unit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.pc        (pc),
		.instr     (instr),
		.step      (step),
		.clear     (clear),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.push      (push),
		.push_byte (push_byte),
		.full      (full)
	);

	fetch_stage fetch_stage_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.step    (step),
		.clear   (clear),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.pc      (pc),
		.instr   (instr)
	);

	byte_fifo byte_fifo_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_byte (push_byte),
		.pop       (pop),
		.head_byte (head_byte),
		.full      (full),
		.empty     (empty)
	);

	uart_tx uart_tx_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.head_byte (head_byte),
		.empty     (empty),
		.pop       (pop),
		.tx        (tx)
	);

endmodule

//--- tests/tb_debug_top.sv
`timescale 1ns/1ps
`include "debug_consts.svh"

module tb_debug_top;
	localparam int CLKS = `DBG_CLKS_PER_BIT;
	localparam int WORDS = `DBG_IMEM_WORDS;
	localparam int IDX_W = $clog2(WORDS);
	// long enough for a five-byte command with gaps plus latency
	localparam int WAIT_LIMIT = 100 * CLKS;

	logic clk;
	logic rst_n;
	logic rx;
	logic tx;

	integer            seed;
	integer            fd;
	integer            rc;
	integer            n;
	logic [8*24-1:0]   name;
	logic [8*128-1:0]  rest;
	logic [7:0]        val;
	logic [7:0]        send_q[$];
	logic [7:0]        exp_q[$];
	logic [7:0]        model_q[$];
	int                tests_pass;
	int                tests_fail;

	// host-side model of pc, memory and write index
	logic [31:0]       ref_pc;
	logic [IDX_W-1:0]  ref_widx;
	logic [31:0]       ref_mem [WORDS];

	debug_top debug_top_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.rx    (rx),
		.tx    (tx)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// serial host
	//////////////////////////////////////////////////////////////////////

	// random idle gap, then start, lsb first, stop
	task automatic drive_byte(input logic [7:0] b);
		int gap;
		gap = ($random(seed) & 32'h7fff_ffff) % (3 * CLKS + 1);
		repeat (gap) @(negedge clk);
		rx = 1'b0;
		repeat (CLKS) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (CLKS) @(negedge clk);
		end
		rx = 1'b1;
		repeat (CLKS) @(negedge clk);
	endtask

	// wait for start bit, then sample mid-bit on falling edges
	task automatic capture_byte(output logic [7:0] b, output bit got_start,
		output bit stop_high);
		int waited;
		waited = 0;
		b = '0;
		stop_high = 1'b0;
		while (tx !== 1'b0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		got_start = (tx === 1'b0);
		if (got_start) begin
			repeat (CLKS / 2) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS) @(negedge clk);
				b[i] = tx;
			end
			// middle of stop bit
			repeat (CLKS) @(negedge clk);
			stop_high = (tx === 1'b1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////
	task automatic dump_model();
		logic [IDX_W-1:0] widx;
		logic [31:0]      w;
		// instruction is the word at pc divided by four
		widx = IDX_W'(ref_pc / 32'd4);
		w = ref_mem[widx];
		for (int i = 0; i < 4; i++)
			model_q.push_back(ref_pc[8*i +: 8]);
		for (int i = 0; i < 4; i++)
			model_q.push_back(w[8*i +: 8]);
	endtask

	task automatic model_apply();
		model_q.delete();
		case (send_q[0])
			`DBG_CMD_WRITE: begin
				ref_mem[ref_widx] = {send_q[4], send_q[3], send_q[2], send_q[1]};
				ref_widx = ref_widx + 1'b1;
				model_q.push_back(`DBG_ANS_OK);
			end
			`DBG_CMD_STEP: begin
				// byte pc wraps at four times the word count
				ref_pc = (ref_pc + 32'd4) % 32'(4 * WORDS);
				dump_model();
			end
			`DBG_CMD_PEEK: dump_model();
			`DBG_CMD_RESET: begin
				ref_pc = '0;
				ref_widx = '0;
				model_q.push_back(`DBG_ANS_OK);
			end
			default: model_q.push_back(`DBG_ANS_BAD);
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// one stimulus line
	//////////////////////////////////////////////////////////////////////
	task automatic run_line();
		logic [7:0] got;
		bit         got_start;
		bit         stop_high;
		bit         alive;
		bit         line_ok;
		bit         model_same;
		line_ok = 1'b1;
		alive = 1'b1;
		model_apply();
		// file answer against the model
		model_same = (model_q.size() == exp_q.size());
		foreach (exp_q[i])
			if (model_same && exp_q[i] != model_q[i])
				model_same = 1'b0;
		assert (model_same) else begin
			$display("test %0s: stimulus answer disagrees with the reference model", name);
			line_ok = 1'b0;
		end
		fork
			begin
				foreach (send_q[i])
					drive_byte(send_q[i]);
			end
			begin
				for (int i = 0; i < exp_q.size() && alive; i++) begin
					capture_byte(got, got_start, stop_high);
					assert (got_start) else begin
						$display("test %0s timed out waiting for answer byte %0d", name, i);
						line_ok = 1'b0;
					end
					alive = got_start;
					if (got_start) begin
						assert (got == exp_q[i]) else begin
							$display("ERR %0t test %0s byte %0d expected %02h received %02h",
								$time, name, i, exp_q[i], got);
							line_ok = 1'b0;
						end
						assert (stop_high) else begin
							$display("test %0s answer byte %0d has no stop bit", name, i);
							line_ok = 1'b0;
						end
					end
				end
			end
		join
		if (line_ok) begin
			tests_pass++;
			$display("%0s pass", name);
		end else begin
			tests_fail++;
			$display("%0s FAIL", name);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		seed = 32'h80230ad5;
		rst_n = 1'b0;
		rx = 1'b1;
		tests_pass = 0;
		tests_fail = 0;
		ref_pc = '0;
		ref_widx = '0;
		for (int i = 0; i < WORDS; i++)
			ref_mem[i] = '0;
		fd = $fopen("tests/debug_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tests/debug_stim.txt");
			$display("Errors found");
			$finish;
		end else begin
			repeat (8) @(negedge clk);
			rst_n = 1'b1;
			repeat (4) @(negedge clk);
			while ($fscanf(fd, "%s", name) == 1) begin
				// a lone # token marks a column note
				if (name == "#") begin
					rc = $fgets(rest, fd);
				end else begin
					send_q.delete();
					exp_q.delete();
					rc = $fscanf(fd, "%d", n);
					for (int i = 0; i < n; i++) begin
						rc = $fscanf(fd, "%h", val);
						send_q.push_back(val);
					end
					rc = $fscanf(fd, "%d", n);
					for (int i = 0; i < n; i++) begin
						rc = $fscanf(fd, "%h", val);
						exp_q.push_back(val);
					end
					run_line();
				end
			end
			$fclose(fd);
			$display("tests passed %0d failed %0d", tests_pass, tests_fail);
			if (tests_fail == 0 && tests_pass > 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

endmodule

//--- sim.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/debug_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/byte_fifo.sv
hdl/fetch_stage.sv
hdl/debug_unit.sv
hdl/debug_top.sv
tests/tb_debug_top.sv

//--- Makefile
# Verilator build and run of the debug unit testbench
VERILATOR ?= verilator
TOP       ?= tb_debug_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the run passes only if the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/debug_stim.txt
# name n_send send_bytes(hex) n_expect expected_bytes(hex)
# dumps are pc then instr, each least significant byte first
peek_reset 1 50 8 00 00 00 00 00 00 00 00
write_0 5 57 78 56 34 12 1 4b
write_1 5 57 ef be ad de 1 4b
write_2 5 57 13 00 02 24 1 4b
step_1 1 53 8 04 00 00 00 ef be ad de
wrap_2 1 53 8 08 00 00 00 13 00 02 24
wrap_3 1 53 8 0c 00 00 00 00 00 00 00
wrap_4 1 53 8 10 00 00 00 00 00 00 00
wrap_5 1 53 8 14 00 00 00 00 00 00 00
wrap_6 1 53 8 18 00 00 00 00 00 00 00
wrap_7 1 53 8 1c 00 00 00 00 00 00 00
wrap_8 1 53 8 20 00 00 00 00 00 00 00
wrap_9 1 53 8 24 00 00 00 00 00 00 00
wrap_10 1 53 8 28 00 00 00 00 00 00 00
wrap_11 1 53 8 2c 00 00 00 00 00 00 00
wrap_12 1 53 8 30 00 00 00 00 00 00 00
wrap_13 1 53 8 34 00 00 00 00 00 00 00
wrap_14 1 53 8 38 00 00 00 00 00 00 00
wrap_15 1 53 8 3c 00 00 00 00 00 00 00
wrap_16 1 53 8 00 00 00 00 78 56 34 12
reset_cmd 1 52 1 4b
peek_after_reset 1 50 8 00 00 00 00 78 56 34 12
unknown_cmd 1 41 1 3f
peek_after_unknown 1 50 8 00 00 00 00 78 56 34 12
burst_step 1 53 8 04 00 00 00 ef be ad de
burst_write 5 57 01 02 03 04 1 4b
burst_peek 1 50 8 04 00 00 00 ef be ad de
burst_bad 1 7a 1 3f
burst_step_2 1 53 8 08 00 00 00 13 00 02 24
burst_write_2 5 57 aa bb cc dd 1 4b
burst_reset 1 52 1 4b
burst_peek_2 1 50 8 00 00 00 00 01 02 03 04
burst_step_3 1 53 8 04 00 00 00 aa bb cc dd
